/* Makefile */
# Verilator build and run for the processor testbench

VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/proc_fwd_if.sv */
//----------------------------------------------------------
// destination info a stage offers back to decode
// data of a load in X is its address, not valid for bypass
//----------------------------------------------------------

`timescale 1ns/1ns

interface proc_fwd_if import proc_types_pkg::*; ();

  logic      valid;
  logic      wen;
  reg_addr_t rd;
  word_t     data;
  logic      is_load;

  modport source (output valid, wen, rd, data, is_load);

  modport sink (input valid, wen, rd, data, is_load);

endinterface

/* common/proc_isa_pkg.sv */
//----------------------------------------------------------
// encodings for the rv32i subset and the control enums
// only word loads and stores, two manager csrs
//----------------------------------------------------------

package proc_isa_pkg;

  // major opcodes
  localparam logic [6:0] c_opc_op     = 7'b0110011;
  localparam logic [6:0] c_opc_op_imm = 7'b0010011;
  localparam logic [6:0] c_opc_load   = 7'b0000011;
  localparam logic [6:0] c_opc_store  = 7'b0100011;
  localparam logic [6:0] c_opc_branch = 7'b1100011;
  localparam logic [6:0] c_opc_jal    = 7'b1101111;
  localparam logic [6:0] c_opc_system = 7'b1110011;

  // funct3 values, grouped by opcode
  localparam logic [2:0] c_f3_add_sub = 3'b000;
  localparam logic [2:0] c_f3_slt     = 3'b010;
  localparam logic [2:0] c_f3_or      = 3'b110;
  localparam logic [2:0] c_f3_and     = 3'b111;
  localparam logic [2:0] c_f3_beq     = 3'b000;
  localparam logic [2:0] c_f3_bne     = 3'b001;
  localparam logic [2:0] c_f3_csrrw   = 3'b001;
  localparam logic [2:0] c_f3_csrrs   = 3'b010;

  localparam logic [6:0] c_f7_sub     = 7'b0100000;

  // manager csrs
  localparam logic [11:0] c_csr_mngr2proc = 12'hfc0;
  localparam logic [11:0] c_csr_proc2mngr = 12'h7c0;

  //----------------------------------------------------------
  // control enums
  //----------------------------------------------------------

  // alu_cp_op2 passes operand 2 through for csrr and jal
  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_cp_op2
  } alu_fn_e;

  typedef enum logic [1:0] {imm_i, imm_s, imm_b, imm_j} imm_type_e;

  typedef enum logic [1:0] {br_none, br_eq, br_ne} br_type_e;

endpackage

/* common/proc_types_pkg.sv */
//----------------------------------------------------------
// datapath widths and reset values shared by all stages
// rv32 only, no compressed instructions
//----------------------------------------------------------

package proc_types_pkg;

  localparam int unsigned c_xlen       = 32;
  localparam int unsigned c_num_regs   = 32;
  localparam int unsigned c_reg_bits   = 5;

  // byte stride between sequential instructions
  localparam int unsigned c_inst_bytes = 4;

  typedef logic [c_xlen-1:0]     word_t;
  typedef logic [c_reg_bits-1:0] reg_addr_t;

  //----------------------------------------------------------
  // reset state
  //----------------------------------------------------------

  // first fetch address after reset
  localparam word_t c_reset_vector = 32'h0000_0200;

  // addi x0, x0, 0 fills empty pipeline slots
  localparam word_t c_nop_inst     = 32'h0000_0013;

endpackage

/* dv/proc_tb.sv */
//----------------------------------------------------------
// directed tests for the core
// programs are placed at 0x200, the expected reset vector
// imem and dmem models hold 1K words and read combinationally
//----------------------------------------------------------

`timescale 1ns/1ns

module proc_tb import proc_types_pkg::*; ();

  localparam int unsigned c_reset_cycles    = 8;
  localparam int unsigned c_cycles_per_word = 20;
  localparam int unsigned c_drain_cycles    = 8;
  localparam word_t       c_prog_base       = 32'h0000_0200;
  localparam int          c_prog_index      = c_prog_base >> 2;

  logic  clk;
  logic  rst_n;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_wen;
  word_t dmem_rdata;
  word_t mngr2proc;
  word_t proc2mngr;
  logic  proc2mngr_valid;

  word_t imem [1024];
  word_t dmem [1024];
  word_t prog [$];
  word_t exp_q [$];
  word_t got_q [$];

  string       test_name     = "startup";
  word_t       lcg_state     = 32'd35;
  int unsigned budget_cycles = 0;
  int unsigned cycle_count   = 0;

  tb_clkgen u_clkgen (.clk);

  proc_top uut (
    .clk, .rst_n, .imem_addr, .imem_data, .dmem_addr, .dmem_wdata, .dmem_wen,
    .dmem_rdata, .mngr2proc, .proc2mngr, .proc2mngr_valid
  );

  //----------------------------------------------------------
  // memory models and manager port monitor
  //----------------------------------------------------------

  assign imem_data  = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (dmem_wen) begin
      dmem[dmem_addr[11:2]] <= dmem_wdata;
    end
  end

  // one-cycle valid pulse sampled mid-cycle
  always @(negedge clk) begin
    if (proc2mngr_valid) begin
      got_q.push_back(proc2mngr);
    end
  end

  //----------------------------------------------------------
  // instruction encoding
  //----------------------------------------------------------

  function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic word_t b_type(int off, int rs1, int rs2, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
            7'b1100011};
  endfunction

  function automatic word_t addi(int rd, int rs1, int imm);
    return i_type(imm, rs1, 0, rd, 7'b0010011);
  endfunction

  function automatic word_t add(int rd, int rs1, int rs2);
    return r_type(0, rs2, rs1, 0, rd);
  endfunction

  function automatic word_t sub(int rd, int rs1, int rs2);
    return r_type('h20, rs2, rs1, 0, rd);
  endfunction

  // register-register logic ops
  function automatic word_t and_rr(int rd, int rs1, int rs2);
    return r_type(0, rs2, rs1, 7, rd);
  endfunction

  function automatic word_t or_rr(int rd, int rs1, int rs2);
    return r_type(0, rs2, rs1, 6, rd);
  endfunction

  function automatic word_t slt(int rd, int rs1, int rs2);
    return r_type(0, rs2, rs1, 2, rd);
  endfunction

  function automatic word_t lw(int rd, int rs1, int imm);
    return i_type(imm, rs1, 2, rd, 7'b0000011);
  endfunction

  function automatic word_t sw(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t beq(int rs1, int rs2, int off);
    return b_type(off, rs1, rs2, 0);
  endfunction

  function automatic word_t bne(int rs1, int rs2, int off);
    return b_type(off, rs1, rs2, 1);
  endfunction

  function automatic word_t jal(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  // csrrs rd, 0xfc0, x0
  function automatic word_t csrr(int rd);
    return i_type('hfc0, 0, 2, rd, 7'b1110011);
  endfunction

  // csrrw x0, 0x7c0, rs1
  function automatic word_t csrw(int rs1);
    return i_type('h7c0, rs1, 1, 0, 7'b1110011);
  endfunction

  //----------------------------------------------------------
  // reference helpers
  //----------------------------------------------------------

  // signs differ means the negative one is smaller
  function automatic word_t less_signed(word_t a, word_t b);
    if (a[31] != b[31]) begin
      return a[31] ? 32'd1 : 32'd0;
    end
    return (a < b) ? 32'd1 : 32'd0;
  endfunction

  function automatic word_t fill_pattern(int idx);
    return (idx << 2) ^ 32'hd00d_0000;
  endfunction

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //----------------------------------------------------------
  // run control and checking
  //----------------------------------------------------------

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_equal(string what, word_t got, word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s, %s got 0x%08h, expected 0x%08h",
                         $time, test_name, what, got, exp));
    end
  endtask

  task automatic emit(word_t inst);
    prog.push_back(inst);
  endtask

  // reset goes low first so the old program cannot touch the new memories
  task automatic hold_reset();
    budget_cycles += c_cycles_per_word * prog.size();
    @(negedge clk);
    rst_n = 1'b0;
    foreach (imem[i]) imem[i] = addi(0, 0, 0);
    foreach (dmem[i]) dmem[i] = fill_pattern(i);
    foreach (prog[i]) imem[c_prog_index + i] = prog[i];
  endtask

  task automatic release_reset();
    repeat (c_reset_cycles) @(negedge clk);
    got_q.delete();
    rst_n = 1'b1;
  endtask

  task automatic collect_pulses();
    while (got_q.size() < exp_q.size()) @(posedge clk);
    repeat (c_drain_cycles) @(negedge clk);
    check_equal("pulse count", got_q.size(), exp_q.size());
    foreach (exp_q[i]) check_equal($sformatf("pulse %0d", i), got_q[i], exp_q[i]);
  endtask

  task automatic start_test(string name);
    test_name = name;
    prog.delete();
    exp_q.delete();
  endtask

  //----------------------------------------------------------
  // directed tests
  //----------------------------------------------------------

  task automatic alu_chain();
    word_t r [10];
    start_test("alu chain");
    emit(addi(1, 0, 'h5a5));
    emit(add(2, 1, 1));
    emit(sub(3, 2, 1));
    emit(and_rr(4, 3, 2));
    emit(or_rr(5, 4, 2));
    emit(slt(6, 3, 5));
    emit(addi(7, 0, -5));
    emit(slt(8, 7, 1));
    emit(slt(9, 1, 7));
    emit(csrw(9));
    emit(csrw(8));
    for (int k = 1; k <= 7; k++) emit(csrw(k));
    r[1] = 32'h5a5;
    r[2] = r[1] + r[1];
    r[3] = r[2] - r[1];
    r[4] = r[3] & r[2];
    r[5] = r[4] | r[2];
    r[6] = less_signed(r[3], r[5]);
    r[7] = -5;
    r[8] = less_signed(r[7], r[1]);
    r[9] = less_signed(r[1], r[7]);
    exp_q.push_back(r[9]);
    exp_q.push_back(r[8]);
    for (int k = 1; k <= 7; k++) exp_q.push_back(r[k]);
    hold_reset();
    release_reset();
    collect_pulses();
  endtask

  task automatic load_store();
    word_t stored;
    start_test("load store");
    emit(addi(1, 0, 'h100));
    emit(addi(2, 0, -677));
    emit(addi(5, 0, 77));
    emit(sw(2, 1, 8));
    emit(lw(3, 1, 8));
    // load-use stall on add and on csrw
    emit(add(4, 3, 5));
    emit(csrw(4));
    emit(csrw(3));
    emit(lw(6, 1, 8));
    emit(csrw(6));
    emit(lw(7, 0, 'h40));
    emit(csrw(7));
    stored = -677;
    exp_q.push_back(stored + 32'd77);
    exp_q.push_back(stored);
    exp_q.push_back(stored);
    exp_q.push_back(fill_pattern('h40 >> 2));
    hold_reset();
    release_reset();
    collect_pulses();
    check_equal("stored word", dmem['h108 >> 2], stored);
  endtask

  task automatic control_flow();
    word_t jal_pc;
    start_test("control flow");
    emit(addi(1, 0, 7));
    emit(addi(2, 0, 7));
    emit(beq(1, 2, 16));
    // branch shadow
    emit(csrw(1));
    emit(csrw(2));
    emit(csrw(1));
    emit(addi(3, 0, 'h11));
    emit(csrw(3));
    emit(bne(1, 2, 12));
    emit(addi(4, 0, 'h22));
    emit(csrw(4));
    jal_pc = c_prog_base + 4 * prog.size();
    emit(jal(5, 12));
    // jal shadow
    emit(csrw(1));
    emit(csrw(2));
    emit(csrw(5));
    emit(addi(6, 0, 'h33));
    emit(csrw(6));
    exp_q.push_back(32'h11);
    exp_q.push_back(32'h22);
    exp_q.push_back(jal_pc + 32'd4);
    exp_q.push_back(32'h33);
    hold_reset();
    release_reset();
    collect_pulses();
  endtask

  task automatic csr_read();
    word_t m;
    start_test("csr read");
    emit(csrr(1));
    emit(addi(2, 1, 1));
    emit(csrw(2));
    // x0 must stay zero even right after a write
    emit(addi(0, 0, 55));
    emit(add(3, 0, 1));
    emit(csrw(0));
    emit(csrw(3));
    m = lcg_next();
    exp_q.push_back(m + 32'd1);
    exp_q.push_back(32'd0);
    exp_q.push_back(m);
    hold_reset();
    mngr2proc = m;
    release_reset();
    collect_pulses();
  endtask

  task automatic random_operands();
    word_t a [16];
    word_t b [16];
    int    addr;
    start_test("random operands");
    for (int k = 0; k < 16; k++) begin
      a[k] = lcg_next();
      b[k] = (k == 0) ? a[k] : lcg_next();
      addr = 'h400 + 8 * k;
      emit(lw(1, 0, addr));
      emit(lw(2, 0, addr + 4));
      emit(add(3, 1, 2));
      emit(sub(4, 1, 2));
      emit(slt(5, 1, 2));
      emit(csrw(3));
      emit(csrw(4));
      emit(csrw(5));
      exp_q.push_back(a[k] + b[k]);
      exp_q.push_back(a[k] - b[k]);
      exp_q.push_back(less_signed(a[k], b[k]));
    end
    hold_reset();
    for (int k = 0; k < 16; k++) begin
      dmem[('h400 >> 2) + 2 * k]     = a[k];
      dmem[('h400 >> 2) + 2 * k + 1] = b[k];
    end
    release_reset();
    collect_pulses();
  endtask

  //----------------------------------------------------------
  // watchdog and main sequence
  //----------------------------------------------------------

  // budget grows as each program is loaded
  initial begin
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > budget_cycles) begin
        stop_run($sformatf("Timeout in %s: no result after %0d cycles",
                           test_name, cycle_count));
      end
    end
  end

  initial begin
    rst_n     = 1'b0;
    mngr2proc = '0;
    alu_chain();
    load_store();
    control_flow();
    csr_read();
    random_operands();
    $display("Regression passed");
    $finish;
  end

endmodule

/* dv/tb_clkgen.sv */
//----------------------------------------------------------
// free-running testbench clock, 100 ns period
//----------------------------------------------------------

`timescale 1ns/1ns

module tb_clkgen (
  output logic clk
);

  localparam int unsigned c_half_period = 50;

  initial begin
    clk = 1'b0;
    forever #(c_half_period) clk = ~clk;
  end

endmodule

/* rtl/proc/proc_decode.sv */
//----------------------------------------------------------
// decode stage with register file and full bypassing
// unsupported encodings decode as a nop
//----------------------------------------------------------

`timescale 1ns/1ns

module proc_decode import proc_types_pkg::*, proc_isa_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     inst_d,
  input  word_t     pc_d,
  input  logic      valid_d,
  input  logic      br_taken,
  input  word_t     mngr2proc,
  proc_fwd_if.sink  fwd_x,
  proc_fwd_if.sink  fwd_m,
  proc_fwd_if.sink  fwd_w,
  output logic      stall_f,
  output logic      jal_taken,
  output word_t     jal_target,
  output logic      valid_dx,
  output word_t     op1_dx,
  output word_t     op2_dx,
  output alu_fn_e   alu_fn_dx,
  output br_type_e  br_type_dx,
  output word_t     br_target_dx,
  output reg_addr_t rd_dx,
  output logic      wen_dx,
  output logic      is_load_dx,
  output logic      is_store_dx,
  output word_t     store_data_dx,
  output logic      is_csrw_dx
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] csr;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  imm_type_e   imm_type;
  word_t       imm;
  word_t       target;
  word_t       rs1_val;
  word_t       rs2_val;
  logic        ctrl_wen;
  logic        rs1_en;
  logic        rs2_en;
  logic        is_jal;
  logic        load_use;
  logic        live;
  word_t       rf_mem [c_num_regs];

  assign opcode = inst_d[6:0];
  assign rd_dx  = inst_d[11:7];
  assign funct3 = inst_d[14:12];
  assign rs1    = inst_d[19:15];
  assign rs2    = inst_d[24:20];
  assign funct7 = inst_d[31:25];
  assign csr    = inst_d[31:20];

  //----------------------------------------------------------
  // control decode
  //----------------------------------------------------------

  always_comb begin
    alu_fn_dx   = alu_add;
    imm_type    = imm_i;
    br_type_dx  = br_none;
    ctrl_wen    = 1'b0;
    rs1_en      = 1'b0;
    rs2_en      = 1'b0;
    is_load_dx  = 1'b0;
    is_store_dx = 1'b0;
    is_csrw_dx  = 1'b0;
    is_jal      = 1'b0;
    case (opcode)
      c_opc_op: begin
        ctrl_wen = 1'b1;
        rs1_en   = 1'b1;
        rs2_en   = 1'b1;
        case (funct3)
          c_f3_add_sub: alu_fn_dx = (funct7 == c_f7_sub) ? alu_sub : alu_add;
          c_f3_slt:     alu_fn_dx = alu_slt;
          c_f3_or:      alu_fn_dx = alu_or;
          c_f3_and:     alu_fn_dx = alu_and;
          default:      ctrl_wen  = 1'b0;
        endcase
      end
      c_opc_op_imm: begin
        // addi only
        ctrl_wen = (funct3 == c_f3_add_sub);
        rs1_en   = 1'b1;
      end
      c_opc_load: begin
        ctrl_wen   = 1'b1;
        rs1_en     = 1'b1;
        is_load_dx = 1'b1;
      end
      c_opc_store: begin
        imm_type    = imm_s;
        rs1_en      = 1'b1;
        rs2_en      = 1'b1;
        is_store_dx = 1'b1;
      end
      c_opc_branch: begin
        imm_type = imm_b;
        rs1_en   = 1'b1;
        rs2_en   = 1'b1;
        if (funct3 == c_f3_beq) begin
          br_type_dx = br_eq;
        end else if (funct3 == c_f3_bne) begin
          br_type_dx = br_ne;
        end
      end
      c_opc_jal: begin
        imm_type  = imm_j;
        alu_fn_dx = alu_cp_op2;
        ctrl_wen  = 1'b1;
        is_jal    = 1'b1;
      end
      c_opc_system: begin
        alu_fn_dx = alu_cp_op2;
        if (funct3 == c_f3_csrrs && csr == c_csr_mngr2proc) begin
          ctrl_wen = 1'b1;
        end else if (funct3 == c_f3_csrrw && csr == c_csr_proc2mngr) begin
          rs1_en     = 1'b1;
          is_csrw_dx = 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    case (imm_type)
      imm_s:   imm = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      imm_b:   imm = {{19{inst_d[31]}}, inst_d[31], inst_d[7], inst_d[30:25],
                      inst_d[11:8], 1'b0};
      imm_j:   imm = {{11{inst_d[31]}}, inst_d[31], inst_d[19:12], inst_d[20],
                      inst_d[30:21], 1'b0};
      default: imm = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  // shared by jal and branches
  assign target = pc_d + imm;

  //----------------------------------------------------------
  // register file and bypass
  //----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rf_mem <= '{default: '0};
    end else if (fwd_w.valid && fwd_w.wen) begin
      rf_mem[fwd_w.rd] <= fwd_w.data;
    end
  end

  // youngest producer wins
  function automatic word_t bypass(reg_addr_t rs);
    if (rs == '0) begin
      return '0;
    end
    if (fwd_x.valid && fwd_x.wen && fwd_x.rd == rs) begin
      return fwd_x.data;
    end
    if (fwd_m.valid && fwd_m.wen && fwd_m.rd == rs) begin
      return fwd_m.data;
    end
    if (fwd_w.valid && fwd_w.wen && fwd_w.rd == rs) begin
      return fwd_w.data;
    end
    return rf_mem[rs];
  endfunction

  always_comb begin
    rs1_val = bypass(rs1);
    rs2_val = bypass(rs2);
  end

  always_comb begin
    case (opcode)
      c_opc_op_imm, c_opc_load, c_opc_store: op2_dx = imm;
      // link address
      c_opc_jal:    op2_dx = pc_d + c_inst_bytes;
      c_opc_system: op2_dx = is_csrw_dx ? rs1_val : mngr2proc;
      default:      op2_dx = rs2_val;
    endcase
  end

  assign op1_dx        = rs1_val;
  assign store_data_dx = rs2_val;
  assign br_target_dx  = target;
  assign jal_target    = target;

  // x0 never counts as a destination
  assign wen_dx = ctrl_wen && (rd_dx != '0);

  //----------------------------------------------------------
  // stall and squash
  //----------------------------------------------------------

  assign load_use = fwd_x.valid && fwd_x.is_load && fwd_x.wen &&
                    ((rs1_en && fwd_x.rd == rs1) || (rs2_en && fwd_x.rd == rs2));

  assign live      = valid_d && !br_taken;
  assign stall_f   = live && load_use;
  assign valid_dx  = live && !load_use;
  assign jal_taken = live && is_jal;

endmodule

/* rtl/proc/proc_execute.sv */
//----------------------------------------------------------
// execute stage, branches resolve here
// a taken branch squashes the instructions in F and D
//----------------------------------------------------------

`timescale 1ns/1ns

module proc_execute import proc_types_pkg::*, proc_isa_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_dx,
  input  word_t      op1_dx,
  input  word_t      op2_dx,
  input  alu_fn_e    alu_fn_dx,
  input  br_type_e   br_type_dx,
  input  word_t      br_target_dx,
  input  reg_addr_t  rd_dx,
  input  logic       wen_dx,
  input  logic       is_load_dx,
  input  logic       is_store_dx,
  input  word_t      store_data_dx,
  input  logic       is_csrw_dx,
  proc_fwd_if.source fwd_x,
  output logic       br_taken,
  output word_t      br_target,
  output logic       valid_xm,
  output word_t      alu_result_xm,
  output reg_addr_t  rd_xm,
  output logic       wen_xm,
  output logic       is_load_xm,
  output logic       is_store_xm,
  output word_t      store_data_xm,
  output logic       is_csrw_xm
);

  word_t    op1_x;
  word_t    op2_x;
  alu_fn_e  alu_fn_x;
  br_type_e br_type_x;
  word_t    alu_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_xm    <= 1'b0;
      wen_xm      <= 1'b0;
      is_load_xm  <= 1'b0;
      is_store_xm <= 1'b0;
      is_csrw_xm  <= 1'b0;
      br_type_x   <= br_none;
    end else begin
      valid_xm    <= valid_dx;
      wen_xm      <= wen_dx;
      is_load_xm  <= is_load_dx;
      is_store_xm <= is_store_dx;
      is_csrw_xm  <= is_csrw_dx;
      br_type_x   <= br_type_dx;
    end
  end

  always_ff @(posedge clk) begin
    op1_x         <= op1_dx;
    op2_x         <= op2_dx;
    alu_fn_x      <= alu_fn_dx;
    br_target     <= br_target_dx;
    rd_xm         <= rd_dx;
    store_data_xm <= store_data_dx;
  end

  always_comb begin
    case (alu_fn_x)
      alu_sub: alu_result = op1_x - op2_x;
      alu_and: alu_result = op1_x & op2_x;
      alu_or:  alu_result = op1_x | op2_x;
      alu_slt: alu_result = {31'b0, $signed(op1_x) < $signed(op2_x)};
      alu_cp_op2: alu_result = op2_x;
      default: alu_result = op1_x + op2_x;
    endcase
  end

  assign alu_result_xm = alu_result;

  assign br_taken = valid_xm && ((br_type_x == br_eq && op1_x == op2_x) ||
                                 (br_type_x == br_ne && op1_x != op2_x));

  // for a load, data is the address and decode stalls instead
  assign fwd_x.valid   = valid_xm;
  assign fwd_x.wen     = wen_xm;
  assign fwd_x.rd      = rd_xm;
  assign fwd_x.data    = alu_result;
  assign fwd_x.is_load = is_load_xm;

endmodule

/* rtl/proc/proc_fetch.sv */
//----------------------------------------------------------
// fetch stage, imem is read combinationally from the pc
// branch redirect from X beats jal redirect from D
//----------------------------------------------------------

`timescale 1ns/1ns

module proc_fetch import proc_types_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  stall_f,
  input  logic  jal_taken,
  input  word_t jal_target,
  input  logic  br_taken,
  input  word_t br_target,
  output word_t imem_addr,
  input  word_t imem_data,
  output word_t inst_d,
  output word_t pc_d,
  output logic  valid_d
);

  word_t pc_f;
  word_t pc_next;

  always_comb begin
    if (br_taken) begin
      pc_next = br_target;
    end else if (jal_taken) begin
      pc_next = jal_target;
    end else if (stall_f) begin
      pc_next = pc_f;
    end else begin
      pc_next = pc_f + c_inst_bytes;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_f <= c_reset_vector;
    end else begin
      pc_f <= pc_next;
    end
  end

  assign imem_addr = pc_f;

  //----------------------------------------------------------
  // F/D register
  //----------------------------------------------------------

  // any redirect kills the instruction fetched this cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d <= 1'b0;
      inst_d  <= c_nop_inst;
    end else if (br_taken || jal_taken) begin
      valid_d <= 1'b0;
      inst_d  <= c_nop_inst;
    end else if (!stall_f) begin
      valid_d <= 1'b1;
      inst_d  <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_f) begin
      pc_d <= pc_f;
    end
  end

endmodule

/* rtl/proc/proc_mem_wb.sv */
//----------------------------------------------------------
// memory and writeback stages
// dmem is read in the same cycle, stores commit on the edge
//----------------------------------------------------------

`timescale 1ns/1ns

module proc_mem_wb import proc_types_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_xm,
  input  word_t      alu_result_xm,
  input  reg_addr_t  rd_xm,
  input  logic       wen_xm,
  input  logic       is_load_xm,
  input  logic       is_store_xm,
  input  word_t      store_data_xm,
  input  logic       is_csrw_xm,
  output word_t      dmem_addr,
  output word_t      dmem_wdata,
  output logic       dmem_wen,
  input  word_t      dmem_rdata,
  proc_fwd_if.source fwd_m,
  proc_fwd_if.source fwd_w,
  output word_t      proc2mngr,
  output logic       proc2mngr_valid
);

  logic      valid_m, wen_m, is_load_m, is_store_m, is_csrw_m;
  logic      valid_w, wen_w, is_load_w, is_csrw_w;
  word_t     alu_result_m;
  word_t     store_data_m;
  word_t     result_m;
  word_t     result_w;
  reg_addr_t rd_m;
  reg_addr_t rd_w;

  //----------------------------------------------------------
  // M stage
  //----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_m    <= 1'b0;
      wen_m      <= 1'b0;
      is_load_m  <= 1'b0;
      is_store_m <= 1'b0;
      is_csrw_m  <= 1'b0;
    end else begin
      valid_m    <= valid_xm;
      wen_m      <= wen_xm;
      is_load_m  <= is_load_xm;
      is_store_m <= is_store_xm;
      is_csrw_m  <= is_csrw_xm;
    end
  end

  always_ff @(posedge clk) begin
    alu_result_m <= alu_result_xm;
    store_data_m <= store_data_xm;
    rd_m         <= rd_xm;
  end

  assign dmem_addr  = alu_result_m;
  assign dmem_wdata = store_data_m;
  assign dmem_wen   = valid_m && is_store_m;

  assign result_m = is_load_m ? dmem_rdata : alu_result_m;

  assign fwd_m.valid   = valid_m;
  assign fwd_m.wen     = wen_m;
  assign fwd_m.rd      = rd_m;
  assign fwd_m.data    = result_m;
  assign fwd_m.is_load = is_load_m;

  //----------------------------------------------------------
  // W stage
  //----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_w   <= 1'b0;
      wen_w     <= 1'b0;
      is_load_w <= 1'b0;
      is_csrw_w <= 1'b0;
    end else begin
      valid_w   <= valid_m;
      wen_w     <= wen_m;
      is_load_w <= is_load_m;
      is_csrw_w <= is_csrw_m;
    end
  end

  always_ff @(posedge clk) begin
    result_w <= result_m;
    rd_w     <= rd_m;
  end

  // also the register file write port
  assign fwd_w.valid   = valid_w;
  assign fwd_w.wen     = wen_w;
  assign fwd_w.rd      = rd_w;
  assign fwd_w.data    = result_w;
  assign fwd_w.is_load = is_load_w;

  assign proc2mngr       = result_w;
  assign proc2mngr_valid = valid_w && is_csrw_w;

endmodule

/* rtl/proc_top.sv */
//----------------------------------------------------------
// five-stage rv32i subset core, memories sit outside
// imem and dmem must answer in the same cycle
//----------------------------------------------------------

`timescale 1ns/1ns

module proc_top import proc_types_pkg::*, proc_isa_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output word_t imem_addr,
  input  word_t imem_data,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_wen,
  input  word_t dmem_rdata,
  input  word_t mngr2proc,
  output word_t proc2mngr,
  output logic  proc2mngr_valid
);

  // F <-> D
  word_t inst_d, pc_d, jal_target;
  logic  valid_d, stall_f, jal_taken;

  // D -> X
  logic      valid_dx, wen_dx, is_load_dx, is_store_dx, is_csrw_dx;
  word_t     op1_dx, op2_dx, br_target_dx, store_data_dx;
  alu_fn_e   alu_fn_dx;
  br_type_e  br_type_dx;
  reg_addr_t rd_dx;

  // X -> F, D, M
  logic      br_taken, valid_xm, wen_xm, is_load_xm, is_store_xm, is_csrw_xm;
  word_t     br_target, alu_result_xm, store_data_xm;
  reg_addr_t rd_xm;

  proc_fwd_if fwd_x ();
  proc_fwd_if fwd_m ();
  proc_fwd_if fwd_w ();

  proc_fetch u_fetch (
    .clk, .rst_n, .stall_f, .jal_taken, .jal_target, .br_taken, .br_target,
    .imem_addr, .imem_data, .inst_d, .pc_d, .valid_d
  );

  proc_decode u_decode (
    .clk, .rst_n, .inst_d, .pc_d, .valid_d, .br_taken, .mngr2proc,
    .fwd_x (fwd_x.sink), .fwd_m (fwd_m.sink), .fwd_w (fwd_w.sink),
    .stall_f, .jal_taken, .jal_target,
    .valid_dx, .op1_dx, .op2_dx, .alu_fn_dx, .br_type_dx, .br_target_dx,
    .rd_dx, .wen_dx, .is_load_dx, .is_store_dx, .store_data_dx, .is_csrw_dx
  );

  proc_execute u_execute (
    .clk, .rst_n,
    .valid_dx, .op1_dx, .op2_dx, .alu_fn_dx, .br_type_dx, .br_target_dx,
    .rd_dx, .wen_dx, .is_load_dx, .is_store_dx, .store_data_dx, .is_csrw_dx,
    .fwd_x (fwd_x.source), .br_taken, .br_target,
    .valid_xm, .alu_result_xm, .rd_xm, .wen_xm, .is_load_xm, .is_store_xm,
    .store_data_xm, .is_csrw_xm
  );

  proc_mem_wb u_mem_wb (
    .clk, .rst_n,
    .valid_xm, .alu_result_xm, .rd_xm, .wen_xm, .is_load_xm, .is_store_xm,
    .store_data_xm, .is_csrw_xm,
    .dmem_addr, .dmem_wdata, .dmem_wen, .dmem_rdata,
    .fwd_m (fwd_m.source), .fwd_w (fwd_w.source),
    .proc2mngr, .proc2mngr_valid
  );

endmodule

/* tb.f */
common/proc_types_pkg.sv
common/proc_isa_pkg.sv
common/proc_fwd_if.sv
rtl/proc/proc_fetch.sv
rtl/proc/proc_decode.sv
rtl/proc/proc_execute.sv
rtl/proc/proc_mem_wb.sv
rtl/proc_top.sv
dv/tb_clkgen.sv
dv/proc_tb.sv
